/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpuTb
FILELIST = compile.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/cpuTb.sv */
`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();

    localparam int numProgs = 6;
    localparam int progWords = 64;
    localparam int bodyFirst = 11;
    localparam int captureFirst = 40;
    localparam int storeFirst = 48;
    localparam int resultBase = 256;
    localparam int dataBase = 320;
    localparam longint watchdogNs = longint'(numProgs) * progWords * 20 * 100;

    logic Clk, reset, run, hostReq, hostWe, hostAck, halted;
    accSize_t hostSize;
    addr_t hostAddr;
    word_t hostWdata, hostRdata;

    logic [7:0] memImg [0:memBytes-1];   // image loaded before each run
    logic [7:0] mdl [0:memBytes-1];      // model memory
    bit touched [0:memBytes-1];          // bytes the program stores to
    word_t mr [0:15];
    flags_t mf;

    aluOp_t opList [0:9] = '{opAnd, opEor, opSub, opRsb, opAdd, opOrr, opMov, opBic, opMvn,
                             opCmp};
    regIdx_t capReg [0:3] = '{4'd10, 4'd11, 4'd13, 4'd14};
    cond_t capCond [0:3] = '{4'h4, 4'h0, 4'h2, 4'h6};   // MI EQ CS VS

    cpuTop u_dut (
        .Clk(Clk), .reset(reset), .run(run), .hostReq(hostReq), .hostWe(hostWe),
        .hostSize(hostSize), .hostAddr(hostAddr), .hostWdata(hostWdata),
        .hostRdata(hostRdata), .hostAck(hostAck), .halted(halted)
    );

    always #50 Clk = ~Clk;

    initial begin
        #(watchdogNs);
        $display("timeout, the core never halted within the time limit");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "test stopped");
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkFlags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            $display("error @%0t: NZCV got %b expected %b", $time, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // returns on the falling edge where ack is seen
    task automatic waitAck();
        do @(negedge Clk); while (!hostAck);
    endtask

    task automatic hostWrite(input addr_t a, input word_t d, input accSize_t sz);
        hostReq = 1'b1;
        hostWe = 1'b1;
        hostSize = sz;
        hostAddr = a;
        hostWdata = d;
        waitAck();
        hostReq = 1'b0;
        hostWe = 1'b0;
    endtask

    task automatic hostRead(input addr_t a, input accSize_t sz, output word_t d);
        hostReq = 1'b1;
        hostWe = 1'b0;
        hostSize = sz;
        hostAddr = a;
        waitAck();
        d = hostRdata;
        hostReq = 1'b0;
    endtask

    function automatic word_t imgWord(input int a);
        return {memImg[a], memImg[a+1], memImg[a+2], memImg[a+3]};
    endfunction

    function automatic word_t readBig(input int a);
        return {mdl[a % memBytes], mdl[(a+1) % memBytes], mdl[(a+2) % memBytes],
                mdl[(a+3) % memBytes]};
    endfunction

    task automatic putWord(input int idx, input word_t w);
        memImg[idx*4] = w[31:24];
        memImg[idx*4+1] = w[23:16];
        memImg[idx*4+2] = w[15:8];
        memImg[idx*4+3] = w[7:0];
    endtask

    function automatic word_t rotr(input word_t v, input int n);
        if (n == 0) return v;
        return (v >> n) | (v << (32 - n));
    endfunction

    function automatic bit condOk(input cond_t c, input flags_t f);
        bit n, z, cf, v;
        n = f[3];
        z = f[2];
        cf = f[1];
        v = f[0];
        case (c)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return cf;
            4'h3: return !cf;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return cf && !z;
            4'h9: return !cf || z;
            4'hA: return n == v;
            4'hB: return n != v;
            4'hC: return !z && (n == v);
            4'hD: return z || (n != v);
            default: return 1'b1;
        endcase
    endfunction

    function automatic cond_t pickCond();
        if ($urandom % 2) return condAl;
        return cond_t'($urandom % 15);
    endfunction

    function automatic word_t genDp();
        aluOp_t op;
        logic s, imm;
        logic [11:0] opnd;
        op = opList[$urandom % 10];
        s = (op == opCmp) ? 1'b1 : 1'($urandom % 2);
        imm = 1'($urandom % 2);
        if (imm) opnd = 12'($urandom);
        else opnd = {5'($urandom), 2'($urandom), 1'b0, 4'($urandom % 13)};
        return {pickCond(), 2'b00, imm, op, s, 4'($urandom % 10), 4'($urandom % 10), opnd};
    endfunction

    // base R12 holds 384 so offsets stay inside 320..511
    function automatic word_t genMem();
        logic u, b, l;
        logic [11:0] off;
        u = 1'($urandom % 2);
        b = 1'($urandom % 2);
        l = 1'($urandom % 2);
        if (b) off = u ? 12'($urandom % 128) : 12'($urandom % 65);
        else off = u ? 12'(4 * ($urandom % 32)) : 12'(4 * ($urandom % 17));
        return {pickCond(), 2'b01, 1'b0, 1'b1, u, b, 1'b0, l, 4'd12,
                4'($urandom % 10), off};
    endfunction

    task automatic buildProgram();
        int i, k, r;
        word_t w;
        for (i = 0; i < memBytes; i++) memImg[i] = 8'($urandom);
        for (r = 0; r < 10; r++) begin
            putWord(r, {condAl, 3'b001, opMov, 1'b0, 4'd0, 4'(r), 12'($urandom)});
        end
        putWord(10, {condAl, 3'b001, opMov, 1'b0, 4'd0, 4'd12, 4'hF, 8'h60});   // R12 = 384
        for (i = bodyFirst; i < captureFirst; i++) begin
            k = int'($urandom % 10);
            if (k < 6) begin
                w = genDp();
            end else if (k < 9) begin
                w = genMem();
            end else begin
                k = int'($urandom % 4);   // instructions skipped
                if (k > captureFirst - 1 - i) k = captureFirst - 1 - i;
                w = {pickCond(), 3'b101, 1'b0, 24'(k - 1)};
            end
            putWord(i, w);
        end
        for (r = 0; r < 4; r++) begin
            putWord(captureFirst + r, {condAl, 3'b001, opMov, 1'b0, 4'd0, capReg[r], 12'd0});
            putWord(captureFirst + 4 + r,
                    {capCond[r], 3'b001, opMov, 1'b0, 4'd0, capReg[r], 12'd1});
        end
        // STR Rr, [PC, #56] lands on 256 + 4r
        for (r = 0; r < 15; r++) begin
            putWord(storeFirst + r, {condAl, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0,
                                     pcReg, 4'(r), 12'd56});
        end
        putWord(progWords - 1, {condHalt, 28'd0});
    endtask

    task automatic shiftModel(input word_t v, input int n, input logic [1:0] kind,
                              input logic cin, output word_t r, output logic c);
        case (kind)
            2'd0: begin
                r = (n == 0) ? v : v << n;
                c = (n == 0) ? cin : v[32-n];
            end
            2'd1: begin
                r = (n == 0) ? '0 : v >> n;
                c = (n == 0) ? v[31] : v[n-1];
            end
            2'd2: begin
                r = (n == 0) ? {32{v[31]}} : word_t'($signed(v) >>> n);
                c = (n == 0) ? v[31] : v[n-1];
            end
            default: begin
                r = rotr(v, n);
                c = (n == 0) ? cin : r[31];
            end
        endcase
    endtask

    function automatic word_t regVal(input logic [3:0] i, input int pc);
        return (i == pcReg) ? word_t'(pc + 8) : mr[i];
    endfunction

    task automatic modelRun();
        int pc, steps, a, j, n;
        word_t ins, av, op2, res;
        logic sc, cOut, vOut, done;
        aluOp_t op;
        for (j = 0; j < memBytes; j++) begin
            mdl[j] = memImg[j];
            touched[j] = 1'b0;
        end
        for (j = 0; j < 16; j++) mr[j] = '0;
        mf = '0;
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 200) begin
            ins = readBig(pc);
            steps++;
            if (ins[31:28] == condHalt) begin
                done = 1'b1;
            end else if (!condOk(ins[31:28], mf)) begin
                pc += 4;
            end else if (ins[27:25] == 3'b101) begin
                pc = pc + 8 + 4 * int'($signed(ins[23:0]));
            end else if (ins[27:26] == 2'b01) begin
                av = regVal(ins[19:16], pc);
                av = ins[23] ? av + {20'd0, ins[11:0]} : av - {20'd0, ins[11:0]};
                a = int'(av[8:0]);
                if (ins[20]) begin
                    mr[ins[15:12]] = ins[22] ? {24'd0, mdl[a]} : readBig(a);
                end else if (ins[22]) begin
                    res = regVal(ins[15:12], pc);
                    mdl[a] = res[7:0];
                    touched[a] = 1'b1;
                end else begin
                    res = regVal(ins[15:12], pc);
                    for (j = 0; j < 4; j++) begin
                        mdl[(a+j) % memBytes] = res[31-8*j -: 8];
                        touched[(a+j) % memBytes] = 1'b1;
                    end
                end
                pc += 4;
            end else begin
                av = regVal(ins[19:16], pc);
                if (ins[25]) begin
                    n = 2 * int'(ins[11:8]);
                    op2 = rotr({24'd0, ins[7:0]}, n);
                    sc = (n == 0) ? mf[1] : op2[31];
                end else begin
                    shiftModel(regVal(ins[3:0], pc), int'(ins[11:7]), ins[6:5], mf[1], op2, sc);
                end
                op = aluOp_t'(ins[24:21]);
                cOut = sc;
                vOut = mf[0];
                case (op)
                    opAnd: res = av & op2;
                    opEor: res = av ^ op2;
                    opOrr: res = av | op2;
                    opBic: res = av & ~op2;
                    opMvn: res = ~op2;
                    opAdd: begin
                        res = av + op2;
                        cOut = (res < av);   // unsigned wrap
                        vOut = (av[31] == op2[31]) && (res[31] != av[31]);
                    end
                    opSub, opCmp: begin
                        res = av - op2;
                        cOut = (av >= op2);
                        vOut = (av[31] != op2[31]) && (res[31] != av[31]);
                    end
                    opRsb: begin
                        res = op2 - av;
                        cOut = (op2 >= av);
                        vOut = (av[31] != op2[31]) && (res[31] != op2[31]);
                    end
                    default: res = op2;
                endcase
                if (ins[20]) mf = {res[31], res == '0, cOut, vOut};
                if (op != opCmp) mr[ins[15:12]] = res;
                pc += 4;
            end
        end
        if (!done) failNow("model program never reached its halt instruction");
    endtask

    // pick a data word the program never stores to
    function automatic int untouchedAddr();
        int a, t;
        for (t = 0; t < 50; t++) begin
            a = dataBase + 4 * int'($urandom % 48);
            if (!touched[a] && !touched[a+1] && !touched[a+2] && !touched[a+3]) return a;
        end
        return -1;
    endfunction

    task automatic runProgram(input int p);
        word_t got;
        word_t capWords [0:3];
        int a, r;
        buildProgram();
        reset = 1'b1;
        repeat (8) @(negedge Clk);
        reset = 1'b0;
        for (a = 0; a < memBytes; a += 4) hostWrite(addr_t'(a), imgWord(a), sizeWord);
        modelRun();
        run = 1'b1;
        while (!halted) begin   // host traffic competes with the core
            a = untouchedAddr();
            if (a >= 0) begin
                hostRead(addr_t'(a), sizeWord, got);
                checkWord(got, imgWord(a), $sformatf("prog %0d host read at %0d", p, a));
            end
            repeat (3) @(negedge Clk);
        end
        run = 1'b0;
        repeat (4) begin
            @(negedge Clk);
            if (!halted) failNow("halted dropped before reset");
        end
        for (r = 0; r < 4; r++) begin
            hostRead(addr_t'(resultBase + 4 * int'(capReg[r])), sizeWord, capWords[r]);
        end
        checkFlags({capWords[0][0], capWords[1][0], capWords[2][0], capWords[3][0]}, mf);
        for (r = 0; r < 15; r++) begin
            hostRead(addr_t'(resultBase + 4 * r), sizeWord, got);
            checkWord(got, mr[r], $sformatf("prog %0d R%0d", p, r));
        end
        for (a = dataBase; a < memBytes; a += 4) begin
            hostRead(addr_t'(a), sizeWord, got);
            checkWord(got, readBig(a), $sformatf("prog %0d memory at %0d", p, a));
        end
    endtask

    initial begin
        word_t d, got;
        int p;
        void'($urandom(32'h9a5b));
        Clk = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        hostReq = 1'b0;
        hostWe = 1'b0;
        hostSize = sizeWord;
        hostAddr = '0;
        hostWdata = '0;
        repeat (8) @(negedge Clk);
        reset = 1'b0;
        @(negedge Clk);
        if (halted !== 1'b0 || hostAck !== 1'b0) failNow("halted or hostAck high after reset");
        d = $urandom;
        hostWrite(addr_t'(400), d, sizeWord);
        hostRead(addr_t'(400), sizeWord, got);
        checkWord(got, d, "host word readback");
        hostRead(addr_t'(401), sizeByte, got);
        checkWord(got, {24'd0, d[23:16]}, "host byte readback");
        for (p = 0; p < numProgs; p++) runProgram(p);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* bench/cpu_checker.sv */
`timescale 1ns/1ns

module cpuChecker import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    input logic busy,
    input logic hostReq,
    input logic hostAck,
    input addr_t hostAddr,
    input logic coreReq,
    input logic coreAck,
    input addr_t coreAddr,
    input logic ramAck
);

    // ack follows a request seen on the previous edge
    hostAckReq: assert property (@(posedge Clk) disable iff (reset) hostAck |-> $past(hostReq))
        else $error("host ack without a host request");
    coreAckReq: assert property (@(posedge Clk) disable iff (reset) coreAck |-> $past(coreReq))
        else $error("core ack without a core request");

    // the acked access closes before the RAM takes another one
    oneInFlight: assert property (@(posedge Clk) disable iff (reset)
        ramAck |=> !ramAck && !busy)
        else $error("a second access overlapped the acked one");
    ackInFlight: assert property (@(posedge Clk) disable iff (reset) ramAck |-> busy)
        else $error("RAM ack with no access in flight");

    hostHold: assert property (@(posedge Clk) disable iff (reset)
        hostReq && !hostAck |=> hostAck || (hostReq && $stable(hostAddr)))
        else $error("host request changed before ack");
    coreHold: assert property (@(posedge Clk) disable iff (reset)
        coreReq && !coreAck |=> coreAck || (coreReq && $stable(coreAddr)))
        else $error("core request changed before ack");

endmodule

bind memArbiter cpuChecker u_checker (
    .Clk(Clk), .reset(reset), .busy(busy),
    .hostReq(hostBus.req), .hostAck(hostBus.ack), .hostAddr(hostBus.addr),
    .coreReq(coreBus.req), .coreAck(coreBus.ack), .coreAddr(coreBus.addr),
    .ramAck(ramBus.ack)
);

/* compile.f */
hdl/cpuPkg.sv
hdl/memBusIf.sv
hdl/shifterOperand.sv
hdl/alu.sv
hdl/datapath.sv
hdl/controlUnit.sv
hdl/memArbiter.sv
hdl/byteRam.sv
hdl/cpuTop.sv
bench/cpu_checker.sv
bench/cpuTb.sv

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input aluOp_t op,
    input word_t a,
    input word_t b,
    input logic shiftCarry,
    input flags_t flagsIn,
    output word_t result,
    output flags_t flagsOut
);

    word_t x, y;
    logic cin, isArith, carry, ovf;
    logic [32:0] sum;

    // one adder, subtraction adds the inverted operand plus one
    always_comb begin
        isArith = 1'b1;
        x = a;
        y = b;
        cin = 1'b0;
        case (op)
            opSub, opCmp: begin
                y = ~b;
                cin = 1'b1;
            end
            opRsb: begin
                x = b;
                y = ~a;
                cin = 1'b1;
            end
            opAdd: cin = 1'b0;
            default: isArith = 1'b0;
        endcase
    end

    assign sum = {1'b0, x} + {1'b0, y} + {32'd0, cin};

    always_comb begin
        case (op)
            opAnd: result = a & b;
            opEor: result = a ^ b;
            opOrr: result = a | b;
            opBic: result = a & ~b;
            opMvn: result = ~b;
            opSub, opRsb, opAdd, opCmp: result = sum[31:0];
            default: result = b;   // MOV
        endcase
    end

    assign carry = isArith ? sum[32] : shiftCarry;   // no borrow on subtract
    assign ovf = isArith ? (x[31] == y[31]) && (sum[31] != x[31]) : flagsIn[0];
    assign flagsOut = {result[31], result == '0, carry, ovf};

endmodule

/* hdl/byteRam.sv */
`timescale 1ns/1ns

module byteRam import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    memBusIf.memory ramBus
);

    logic [7:0] mem [0:memBytes-1];
    addr_t a1, a2, a3;
    logic start;

    assign a1 = ramBus.addr + addr_t'(1);
    assign a2 = ramBus.addr + addr_t'(2);
    assign a3 = ramBus.addr + addr_t'(3);
    assign start = ramBus.req && !ramBus.ack && !reset;   // idle while no ack out

    always_ff @(posedge Clk) begin
        if (reset) ramBus.ack <= 1'b0;
        else ramBus.ack <= start;
    end

    // big-endian, the lowest address holds the top byte
    always_ff @(posedge Clk) begin
        if (start) begin
            if (ramBus.we) begin
                if (ramBus.size == sizeByte) begin
                    mem[ramBus.addr] <= ramBus.wdata[7:0];
                end else begin
                    mem[ramBus.addr] <= ramBus.wdata[31:24];
                    mem[a1] <= ramBus.wdata[23:16];
                    mem[a2] <= ramBus.wdata[15:8];
                    mem[a3] <= ramBus.wdata[7:0];
                end
            end else if (ramBus.size == sizeByte) begin
                ramBus.rdata <= {24'd0, mem[ramBus.addr]};
            end else begin
                ramBus.rdata <= {mem[ramBus.addr], mem[a1], mem[a2], mem[a3]};
            end
        end
    end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    input logic run,
    input word_t instr,
    input logic condPass,
    memBusIf.requester coreBus,
    output logic irLoad,
    output logic marLoad,
    output logic mdrLoad,
    output logic mdrFromMem,
    output logic regWrite,
    output logic flagWrite,
    output logic pcIncr,
    output logic pcBranch,
    output logic addrFromPc,
    output logic halted
);

    cpuState_t state;
    cpuState_t nextState;
    logic [2:0] instrClass;
    logic isLoad;

    assign instrClass = instr[27:25];
    assign isLoad = instr[20];
    assign halted = (state == stHalted);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        irLoad = 1'b0;
        marLoad = 1'b0;
        mdrLoad = 1'b0;
        mdrFromMem = 1'b0;
        regWrite = 1'b0;
        flagWrite = 1'b0;
        pcIncr = 1'b0;
        pcBranch = 1'b0;
        addrFromPc = 1'b0;
        coreBus.req = 1'b0;
        coreBus.we = 1'b0;
        coreBus.size = sizeWord;
        case (state)
            stIdle: begin
                if (run) begin   // point MAR at the next instruction
                    marLoad = 1'b1;
                    addrFromPc = 1'b1;
                    nextState = stFetch;
                end
            end
            stFetch: begin
                coreBus.req = 1'b1;
                if (coreBus.ack) begin
                    irLoad = 1'b1;
                    nextState = stDecode;
                end
            end
            stDecode: begin
                if (instr[31:28] == condHalt) begin
                    nextState = stHalted;
                end else if (!condPass) begin
                    pcIncr = 1'b1;   // skipped, retire right away
                    nextState = stIdle;
                end else begin
                    case (instrClass)
                        3'b000, 3'b001: nextState = stExecute;
                        3'b010: nextState = stMemAddr;
                        3'b101: nextState = stBranch;
                        default: begin
                            pcIncr = 1'b1;
                            nextState = stIdle;
                        end
                    endcase
                end
            end
            stExecute: begin
                regWrite = 1'b1;
                flagWrite = instr[20];   // S bit
                pcIncr = 1'b1;
                nextState = stIdle;
            end
            stMemAddr: begin
                marLoad = 1'b1;
                mdrLoad = !isLoad;   // store data from Rd
                nextState = stMemAccess;
            end
            stMemAccess: begin
                coreBus.req = 1'b1;
                coreBus.we = !isLoad;
                coreBus.size = accSize_t'(instr[22]);
                if (coreBus.ack) begin
                    if (isLoad) begin
                        mdrLoad = 1'b1;
                        mdrFromMem = 1'b1;
                        nextState = stLoadWrite;
                    end else begin
                        pcIncr = 1'b1;
                        nextState = stIdle;
                    end
                end
            end
            stLoadWrite: begin
                regWrite = 1'b1;
                pcIncr = 1'b1;
                nextState = stIdle;
            end
            stBranch: begin
                pcBranch = 1'b1;
                nextState = stIdle;
            end
            stHalted: nextState = stHalted;   // only reset leaves
            default: nextState = stIdle;
        endcase
    end

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    localparam int memBytes = 512;
    localparam int addrWidth = $clog2(memBytes);

    typedef logic [31:0] word_t;
    typedef logic [addrWidth-1:0] addr_t;
    typedef logic [3:0] regIdx_t;
    typedef logic [3:0] flags_t;   // N Z C V, high bit first
    typedef logic [3:0] aluOp_t;
    typedef logic [3:0] cond_t;
    typedef logic accSize_t;

    // matches the B bit of a load/store
    localparam accSize_t sizeWord = 1'b0;
    localparam accSize_t sizeByte = 1'b1;

    // data processing opcodes, ARM encoding
    localparam aluOp_t opAnd = 4'b0000;
    localparam aluOp_t opEor = 4'b0001;
    localparam aluOp_t opSub = 4'b0010;
    localparam aluOp_t opRsb = 4'b0011;
    localparam aluOp_t opAdd = 4'b0100;
    localparam aluOp_t opCmp = 4'b1010;
    localparam aluOp_t opOrr = 4'b1100;
    localparam aluOp_t opMov = 4'b1101;
    localparam aluOp_t opBic = 4'b1110;
    localparam aluOp_t opMvn = 4'b1111;

    localparam cond_t condAl = 4'hE;
    localparam cond_t condHalt = 4'hF;   // any instruction with this stops the core

    localparam regIdx_t pcReg = 4'd15;
    localparam word_t pcAhead = 32'd8;    // pipeline view of the PC
    localparam word_t instrBytes = 32'd4;

    typedef enum logic [3:0] {
        stIdle,
        stFetch,
        stDecode,
        stExecute,
        stMemAddr,
        stMemAccess,
        stLoadWrite,
        stBranch,
        stHalted
    } cpuState_t;

endpackage

/* hdl/cpuTop.sv */
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    input logic run,
    input logic hostReq,
    input logic hostWe,
    input accSize_t hostSize,
    input addr_t hostAddr,
    input word_t hostWdata,
    output word_t hostRdata,
    output logic hostAck,
    output logic halted
);

    memBusIf coreBus ();
    memBusIf hostBus ();
    memBusIf ramBus ();

    word_t instr;
    logic condPass;
    logic irLoad, marLoad, mdrLoad, mdrFromMem;
    logic regWrite, flagWrite, pcIncr, pcBranch, addrFromPc;

    // host side of the shared RAM
    assign hostBus.req = hostReq;
    assign hostBus.we = hostWe;
    assign hostBus.size = hostSize;
    assign hostBus.addr = hostAddr;
    assign hostBus.wdata = hostWdata;
    assign hostRdata = hostBus.rdata;
    assign hostAck = hostBus.ack;

    controlUnit u_control (
        .Clk(Clk), .reset(reset), .run(run), .instr(instr), .condPass(condPass),
        .coreBus(coreBus), .irLoad(irLoad), .marLoad(marLoad), .mdrLoad(mdrLoad),
        .mdrFromMem(mdrFromMem), .regWrite(regWrite), .flagWrite(flagWrite),
        .pcIncr(pcIncr), .pcBranch(pcBranch), .addrFromPc(addrFromPc), .halted(halted)
    );

    datapath u_datapath (
        .Clk(Clk), .reset(reset), .irLoad(irLoad), .marLoad(marLoad), .mdrLoad(mdrLoad),
        .mdrFromMem(mdrFromMem), .regWrite(regWrite), .flagWrite(flagWrite),
        .pcIncr(pcIncr), .pcBranch(pcBranch), .addrFromPc(addrFromPc),
        .coreBus(coreBus), .instr(instr), .condPass(condPass)
    );

    memArbiter u_arbiter (
        .Clk(Clk), .reset(reset), .coreBus(coreBus), .hostBus(hostBus), .ramBus(ramBus)
    );

    byteRam u_ram (.Clk(Clk), .reset(reset), .ramBus(ramBus));

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ns

module datapath import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    input logic irLoad,
    input logic marLoad,
    input logic mdrLoad,
    input logic mdrFromMem,
    input logic regWrite,
    input logic flagWrite,
    input logic pcIncr,
    input logic pcBranch,
    input logic addrFromPc,
    memBusIf.requester coreBus,
    output word_t instr,
    output logic condPass
);

    word_t regs [0:15];
    word_t ir;
    addr_t mar;
    word_t mdr;
    flags_t flags;

    regIdx_t rnIdx, rdIdx, rmIdx;
    word_t pcRead, rnVal, rdVal, rmVal;
    word_t shOp, aluRes, effAddr, offset12, branchOff, wrData;
    logic shCarry, isMem, isCmp;
    flags_t aluFlags;
    cond_t cond;

    assign rnIdx = ir[19:16];
    assign rdIdx = ir[15:12];
    assign rmIdx = ir[3:0];

    // R15 reads as the instruction address plus 8
    assign pcRead = regs[pcReg] + pcAhead;
    assign rnVal = (rnIdx == pcReg) ? pcRead : regs[rnIdx];
    assign rdVal = (rdIdx == pcReg) ? pcRead : regs[rdIdx];
    assign rmVal = (rmIdx == pcReg) ? pcRead : regs[rmIdx];

    shifterOperand u_shifter (
        .instr(ir),
        .rm(rmVal),
        .carryIn(flags[1]),
        .operand(shOp),
        .carryOut(shCarry)
    );

    alu u_alu (
        .op(aluOp_t'(ir[24:21])),
        .a(rnVal),
        .b(shOp),
        .shiftCarry(shCarry),
        .flagsIn(flags),
        .result(aluRes),
        .flagsOut(aluFlags)
    );

    assign offset12 = {20'd0, ir[11:0]};
    assign effAddr = ir[23] ? rnVal + offset12 : rnVal - offset12;   // U bit
    assign branchOff = {{6{ir[23]}}, ir[23:0], 2'b00};

    assign isMem = (ir[27:26] == 2'b01);
    assign isCmp = (ir[27:26] == 2'b00) && (aluOp_t'(ir[24:21]) == opCmp);
    assign wrData = isMem ? mdr : aluRes;

    always_ff @(posedge Clk) begin
        if (reset) begin
            regs <= '{default: '0};
            flags <= '0;
        end else begin
            if (regWrite && rdIdx != pcReg && !isCmp) begin
                regs[rdIdx] <= wrData;
            end
            if (pcIncr) begin
                regs[pcReg] <= regs[pcReg] + instrBytes;
            end else if (pcBranch) begin
                regs[pcReg] <= pcRead + branchOff;
            end
            if (flagWrite) begin
                flags <= aluFlags;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (irLoad) ir <= coreBus.rdata;
        if (marLoad) mar <= addrFromPc ? addr_t'(regs[pcReg]) : addr_t'(effAddr);
        if (mdrLoad) mdr <= mdrFromMem ? coreBus.rdata : rdVal;
    end

    assign coreBus.addr = mar;
    assign coreBus.wdata = mdr;
    assign instr = ir;

    // condition test, flags are N Z C V
    assign cond = ir[31:28];
    always_comb begin
        case (cond)
            4'h0: condPass = flags[2];                              // EQ
            4'h1: condPass = !flags[2];                             // NE
            4'h2: condPass = flags[1];                              // CS
            4'h3: condPass = !flags[1];                             // CC
            4'h4: condPass = flags[3];                              // MI
            4'h5: condPass = !flags[3];                             // PL
            4'h6: condPass = flags[0];                              // VS
            4'h7: condPass = !flags[0];                             // VC
            4'h8: condPass = flags[1] && !flags[2];                 // HI
            4'h9: condPass = !flags[1] || flags[2];                 // LS
            4'hA: condPass = (flags[3] == flags[0]);                // GE
            4'hB: condPass = (flags[3] != flags[0]);                // LT
            4'hC: condPass = !flags[2] && (flags[3] == flags[0]);   // GT
            4'hD: condPass = flags[2] || (flags[3] != flags[0]);    // LE
            condAl: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

endmodule

/* hdl/memArbiter.sv */
`timescale 1ns/1ns

module memArbiter (
    input logic Clk,
    input logic reset,
    memBusIf.memory coreBus,
    memBusIf.memory hostBus,
    memBusIf.requester ramBus
);

    logic busy;        // an access is in flight
    logic ownerHost;
    logic selHost;

    // host wins when the RAM is free, owner is locked until ack
    assign selHost = busy ? ownerHost : hostBus.req;

    assign ramBus.req = selHost ? hostBus.req : coreBus.req;
    assign ramBus.we = selHost ? hostBus.we : coreBus.we;
    assign ramBus.size = selHost ? hostBus.size : coreBus.size;
    assign ramBus.addr = selHost ? hostBus.addr : coreBus.addr;
    assign ramBus.wdata = selHost ? hostBus.wdata : coreBus.wdata;

    assign hostBus.ack = busy && ownerHost && ramBus.ack;
    assign coreBus.ack = busy && !ownerHost && ramBus.ack;
    assign hostBus.rdata = ramBus.rdata;   // qualified by ack
    assign coreBus.rdata = ramBus.rdata;

    always_ff @(posedge Clk) begin
        if (reset) begin
            busy <= 1'b0;
            ownerHost <= 1'b0;
        end else if (!busy && ramBus.req) begin
            busy <= 1'b1;
            ownerHost <= selHost;
        end else if (busy && ramBus.ack) begin
            busy <= 1'b0;
        end
    end

endmodule

/* hdl/memBusIf.sv */
`timescale 1ns/1ns

// req is a level held until ack, ack is a single cycle pulse
interface memBusIf import cpuPkg::*; ();

    logic req;
    logic we;
    accSize_t size;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic ack;

    modport requester (
        output req, we, size, addr, wdata,
        input rdata, ack
    );

    modport memory (
        input req, we, size, addr, wdata,
        output rdata, ack
    );

endinterface

/* hdl/shifterOperand.sv */
`timescale 1ns/1ns

module shifterOperand import cpuPkg::*; (
    input word_t instr,
    input word_t rm,
    input logic carryIn,
    output word_t operand,
    output logic carryOut
);

    word_t imm;
    logic [4:0] rot;
    logic [4:0] amt;
    logic [63:0] immRot, regRot;
    logic [32:0] lslWide, lsrWide;
    logic signed [32:0] asrWide;

    assign imm = {24'd0, instr[7:0]};
    assign rot = {instr[11:8], 1'b0};
    assign immRot = {imm, imm} >> rot;

    assign amt = instr[11:7];
    // the extra bit catches the last bit shifted out
    assign lslWide = {1'b0, rm} << amt;
    assign lsrWide = {rm, 1'b0} >> amt;
    assign asrWide = $signed({rm, 1'b0}) >>> amt;
    assign regRot = {rm, rm} >> amt;

    always_comb begin
        if (instr[25]) begin
            operand = immRot[31:0];
            carryOut = (rot == 5'd0) ? carryIn : immRot[31];
        end else begin
            case (instr[6:5])
                2'b00: begin   // LSL
                    operand = lslWide[31:0];
                    carryOut = (amt == 5'd0) ? carryIn : lslWide[32];
                end
                2'b01: begin   // LSR, zero means 32
                    operand = (amt == 5'd0) ? '0 : lsrWide[32:1];
                    carryOut = (amt == 5'd0) ? rm[31] : lsrWide[0];
                end
                2'b10: begin   // ASR, zero means 32
                    operand = (amt == 5'd0) ? {32{rm[31]}} : asrWide[32:1];
                    carryOut = (amt == 5'd0) ? rm[31] : asrWide[0];
                end
                default: begin   // ROR without RRX
                    operand = regRot[31:0];
                    carryOut = (amt == 5'd0) ? carryIn : regRot[31];
                end
            endcase
        end
    end

endmodule
